//--- Bender.yml
package:
  name: vmul_unit

sources:
  - include_dirs:
      - common
    files:
      - common/vmul_pkg.sv
      - common/vmul_result_if.sv
      - hw/vmul/simd_mul.sv
      - hw/vmul/vmul_cluster.sv
      - hw/vinsn_queue.sv
      - hw/result_queue.sv
      - hw/vmul_unit.sv
      - target: test
        files:
          - dv/tb_vmul_unit.sv

//--- common/vmul_consts.svh
/* Vector multiplier constants */

`ifndef VMUL_CONSTS_SVH
`define VMUL_CONSTS_SVH

// Datapath and queue sizes
`define VMUL_ELEN          64
`define VMUL_VINSN_DEPTH   4
`define VMUL_RESQ_DEPTH    2
`define VMUL_NR_VINSN      8
`define VMUL_VL_WIDTH      10
`define VMUL_VADDR_WIDTH   8

// Multiplier pipeline stages per element width
`define VMUL_LAT_EW64      2
`define VMUL_LAT_EW32      2
`define VMUL_LAT_EW16      1
`define VMUL_LAT_EW8       1

`endif

//--- common/vmul_pkg.sv
/* Vector multiplier types */

`default_nettype none

`include "vmul_consts.svh"

package vmul_pkg;

  // Data word and its byte enables
  typedef logic [`VMUL_ELEN-1:0]             elen_t;
  typedef logic [`VMUL_ELEN/8-1:0]           strb_t;

  typedef logic [$clog2(`VMUL_NR_VINSN)-1:0] vid_t;
  typedef logic [`VMUL_VL_WIDTH-1:0]         vlen_t;
  typedef logic [`VMUL_VADDR_WIDTH-1:0]      vaddr_t;

  // Elements per word is 2**(3-vsew)
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [1:0] {
    VMUL,
    VMULHU,
    VMACC
  } mul_op_e;

  typedef struct packed {
    vid_t    id;
    mul_op_e op;
    vew_e    vsew;
    vlen_t   vl;
    vaddr_t  vd_addr;
    logic    use_scalar_op;
    elen_t   scalar_op;
  } vmul_operation_t;

endpackage

`default_nettype wire

//--- common/vmul_result_if.sv
/* Multiplier result channel */

`timescale 1ns/1ps
`default_nettype none

interface vmul_result_if;

  logic            valid;
  logic            ready;
  vmul_pkg::elen_t wdata;

  modport producer (
    output valid,
    output wdata,
    input  ready
  );

  modport consumer (
    input  valid,
    input  wdata,
    output ready
  );

  // Word counting in the instruction queue
  modport monitor (
    input valid,
    input ready
  );

endinterface

`default_nettype wire

//--- dv/tb_vmul_unit.sv
/* Vector multiply unit testbench */

`timescale 1ns/1ps
`default_nettype none

`include "vmul_consts.svh"

module tb_vmul_unit;

  typedef struct packed {
    vmul_pkg::vid_t   id;
    vmul_pkg::vaddr_t addr;
    vmul_pkg::elen_t  data;
    vmul_pkg::strb_t  be;
    logic             last;
  } wr_t;

  logic                      clk_i;
  logic                      rst_ni;
  vmul_pkg::vmul_operation_t op_i;
  logic                      op_valid_i;
  logic                      op_ready_o;
  vmul_pkg::elen_t [2:0]     operand_i;
  logic [2:0]                operand_valid_i;
  logic [2:0]                operand_ready_o;
  logic                      result_req_o;
  vmul_pkg::vid_t            result_id_o;
  vmul_pkg::vaddr_t          result_addr_o;
  vmul_pkg::elen_t           result_wdata_o;
  vmul_pkg::strb_t           result_be_o;
  logic                      result_gnt_i;
  logic [`VMUL_NR_VINSN-1:0] vinsn_done_o;

  logic [31:0]               lfsr = 32'h15a1ac0b;
  vmul_pkg::vmul_operation_t send_q [$];
  vmul_pkg::elen_t           vs1_q [$];
  vmul_pkg::elen_t           vs2_q [$];
  vmul_pkg::elen_t           vd_q [$];
  wr_t                       exp_q [$];
  wr_t                       last_req;
  logic                      req_waiting;
  logic                      sparse_gnt;
  vmul_pkg::vid_t            next_id;
  int                        held;
  int                        full_cycles;
  int                        writes;
  int                        errors;
  int                        timeouts;

  always #4 clk_i = ~clk_i;

  vmul_unit vmul_unit_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .op_i            (op_i),
    .op_valid_i      (op_valid_i),
    .op_ready_o      (op_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .result_req_o    (result_req_o),
    .result_id_o     (result_id_o),
    .result_addr_o   (result_addr_o),
    .result_wdata_o  (result_wdata_o),
    .result_be_o     (result_be_o),
    .result_gnt_i    (result_gnt_i),
    .vinsn_done_o    (vinsn_done_o)
  );

  //////////////////////////////////////////////////
  // Stimulus and reference model
  //////////////////////////////////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] r;
    logic        bit_out;
    r = '0;
    for (int i = 0; i < n; i++) begin
      bit_out = lfsr[0];
      lfsr = lfsr >> 1;
      if (bit_out) lfsr = lfsr ^ 32'h80200003;
      r = {r[62:0], bit_out};
    end
    return r;
  endfunction

  function automatic vmul_pkg::elen_t replicate(vmul_pkg::elen_t s, vmul_pkg::vew_e vsew);
    vmul_pkg::elen_t r;
    for (int i = 0; i < 64; i++) begin
      r[i] = s[i % (8 << int'(vsew))];
    end
    return r;
  endfunction

  function automatic vmul_pkg::elen_t model_word(vmul_pkg::mul_op_e op, vmul_pkg::vew_e vsew,
                                                 vmul_pkg::elen_t a, vmul_pkg::elen_t b,
                                                 vmul_pkg::elen_t c);
    int unsigned     ew;
    logic [127:0]    mask;
    logic [127:0]    av;
    logic [127:0]    bv;
    logic [127:0]    cv;
    logic [127:0]    p;
    logic [127:0]    r;
    vmul_pkg::elen_t res;
    ew   = 8 << int'(vsew);
    mask = (128'd1 << ew) - 128'd1;
    res  = '0;
    for (int e = 0; e < 64 / ew; e++) begin
      av = (128'(a) >> (e * ew)) & mask;
      bv = (128'(b) >> (e * ew)) & mask;
      cv = (128'(c) >> (e * ew)) & mask;
      p  = av * bv;
      if (op == vmul_pkg::VMULHU) r = (p >> ew) & mask;
      else if (op == vmul_pkg::VMACC) r = (cv + p) & mask;
      else r = p & mask;
      res = res | vmul_pkg::elen_t'(r << (e * ew));
    end
    return res;
  endfunction

  task automatic report_error(string msg);
    errors++;
    $display("ERROR %0d ns: %s", $time, msg);
  endtask

  task automatic send_insn(vmul_pkg::mul_op_e op, vmul_pkg::vew_e vsew, int vl, logic scalar);
    vmul_pkg::vmul_operation_t insn;
    insn.id            = next_id;
    insn.op            = op;
    insn.vsew          = vsew;
    insn.vl            = vmul_pkg::vlen_t'(vl);
    insn.vd_addr       = vmul_pkg::vaddr_t'(rand_bits(8));
    insn.use_scalar_op = scalar;
    insn.scalar_op     = rand_bits(64);
    send_q.push_back(insn);
    next_id = next_id + 1'b1;
  endtask

  // Operand words and expected writes for one accepted instruction
  task automatic accept_insn(vmul_pkg::vmul_operation_t op);
    int              epw;
    int              nwords;
    int              n;
    vmul_pkg::elen_t a;
    vmul_pkg::elen_t b;
    vmul_pkg::elen_t c;
    wr_t             w;
    if (op.vl == '0) return;
    epw    = 8 >> int'(op.vsew);
    nwords = (int'(op.vl) + epw - 1) / epw;
    held++;
    for (int i = 0; i < nwords; i++) begin
      a = rand_bits(64);
      b = rand_bits(64);
      c = rand_bits(64);
      if (op.use_scalar_op) a = replicate(op.scalar_op, op.vsew);
      else vs1_q.push_back(a);
      vs2_q.push_back(b);
      if (op.op == vmul_pkg::VMACC) vd_q.push_back(c);
      n      = (int'(op.vl) - i * epw < epw) ? int'(op.vl) - i * epw : epw;
      w.id   = op.id;
      w.addr = op.vd_addr + vmul_pkg::vaddr_t'(i);
      w.data = model_word(op.op, op.vsew, a, b, c);
      w.be   = vmul_pkg::strb_t'((1 << (n << int'(op.vsew))) - 1);
      w.last = (i == nwords - 1);
      exp_q.push_back(w);
    end
  endtask

  //////////////////////////////////////////////////
  // Per-cycle checks and driving
  //////////////////////////////////////////////////

  task automatic check_cycle();
    logic [`VMUL_NR_VINSN-1:0] exp_done;
    wr_t                       cur;
    wr_t                       w;
    exp_done = '0;
    cur      = '{id: result_id_o, addr: result_addr_o, data: result_wdata_o,
                 be: result_be_o, last: 1'b0};
    assert (op_ready_o == (held < `VMUL_VINSN_DEPTH))
      else report_error($sformatf("op_ready_o is %b with %0d instructions held",
                                  op_ready_o, held));
    if (held == `VMUL_VINSN_DEPTH) full_cycles++;
    if (req_waiting) begin
      assert (result_req_o && cur == last_req)
        else report_error("write request changed before it was granted");
    end
    req_waiting = result_req_o && !result_gnt_i;
    last_req    = cur;
    if (result_req_o && result_gnt_i) begin
      assert (exp_q.size() != 0) else report_error("register file write with no word expected");
      if (exp_q.size() != 0) begin
        w = exp_q.pop_front();
        writes++;
        assert (cur.id == w.id && cur.addr == w.addr && cur.data == w.data && cur.be == w.be)
          else report_error($sformatf("write id %0d addr %0h data %h be %b, %s %0d %0h %h %b",
                                      cur.id, cur.addr, cur.data, cur.be, "expected",
                                      w.id, w.addr, w.data, w.be));
        if (w.last) begin
          exp_done[w.id] = 1'b1;
          held--;
        end
      end
    end
    assert (vinsn_done_o == exp_done)
      else report_error($sformatf("done pulses %b, expected %b", vinsn_done_o, exp_done));
    // Operand queue pops
    if (operand_ready_o[0]) begin
      assert (operand_valid_i[0]) else report_error("vs1 popped while not valid");
      if (vs1_q.size() != 0) void'(vs1_q.pop_front());
    end
    if (operand_ready_o[1]) begin
      assert (operand_valid_i[1]) else report_error("vs2 popped while not valid");
      if (vs2_q.size() != 0) void'(vs2_q.pop_front());
    end
    if (operand_ready_o[2]) begin
      assert (operand_valid_i[2]) else report_error("vd popped while not valid");
      if (vd_q.size() != 0) void'(vd_q.pop_front());
    end
    if (op_valid_i && op_ready_o) begin
      accept_insn(op_i);
      void'(send_q.pop_front());
    end
  endtask

  task automatic drive_inputs();
    op_valid_i         = (send_q.size() != 0);
    op_i               = op_valid_i ? send_q[0] : '0;
    operand_i[0]       = (vs1_q.size() != 0) ? vs1_q[0] : '0;
    operand_i[1]       = (vs2_q.size() != 0) ? vs2_q[0] : '0;
    operand_i[2]       = (vd_q.size() != 0) ? vd_q[0] : '0;
    operand_valid_i[0] = (vs1_q.size() != 0) && (rand_bits(2) != 0);
    operand_valid_i[1] = (vs2_q.size() != 0) && (rand_bits(2) != 0);
    operand_valid_i[2] = (vd_q.size() != 0) && (rand_bits(2) != 0);
    result_gnt_i       = sparse_gnt ? (rand_bits(2) == 0) : (rand_bits(1) != 0);
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) check_cycle();
    #1;
    drive_inputs();
  end

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while ((send_q.size() != 0 || exp_q.size() != 0 || held != 0) && cycles < 4000) begin
      @(negedge clk_i);
      cycles++;
    end
    if (send_q.size() != 0 || exp_q.size() != 0 || held != 0) begin
      timeouts++;
      $display("Timeout: the unit did not complete its instructions within %0d cycles", cycles);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    op_i = '0;
    op_valid_i = 1'b0;
    operand_i = '0;
    operand_valid_i = 3'b000;
    result_gnt_i = 1'b0;
    req_waiting = 1'b0;
    last_req = '0;
    sparse_gnt = 1'b0;
    next_id = '0;
    held = 0;
    full_cycles = 0;
    writes = 0;
    errors = 0;
    timeouts = 0;
    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    assert (op_ready_o && operand_ready_o == 3'b000 && !result_req_o && vinsn_done_o == '0)
      else report_error("outputs not idle after reset");

    // Full words at every width, then high product, accumulate and scalar
    for (int w = 0; w < 4; w++) begin
      send_insn(vmul_pkg::VMUL, vmul_pkg::vew_e'(w), 3 * (8 >> w), 1'b0);
      send_insn(vmul_pkg::VMULHU, vmul_pkg::vew_e'(w), 2 * (8 >> w), 1'b0);
      send_insn(vmul_pkg::VMACC, vmul_pkg::vew_e'(w), 2 * (8 >> w), 1'b0);
      send_insn(vmul_pkg::VMUL, vmul_pkg::vew_e'(w), 2 * (8 >> w), 1'b1);
      send_insn(vmul_pkg::VMACC, vmul_pkg::vew_e'(w), 8 >> w, 1'b1);
      wait_idle();
    end

    // Partial tail words
    for (int w = 0; w < 3; w++) begin
      send_insn(vmul_pkg::VMUL, vmul_pkg::vew_e'(w), 2 * (8 >> w) + 1, 1'b0);
      send_insn(vmul_pkg::VMACC, vmul_pkg::vew_e'(w), (8 >> w) - 1, 1'b1);
    end
    wait_idle();

    // Back-to-back random instructions under sparse grants
    sparse_gnt = 1'b1;
    for (int i = 0; i < 24; i++) begin
      send_insn(vmul_pkg::mul_op_e'(rand_bits(2) % 3), vmul_pkg::vew_e'(rand_bits(2)),
                (i == 11) ? 0 : int'(rand_bits(5)) + 1, rand_bits(1) != 0);
    end
    wait_idle();
    sparse_gnt = 1'b0;
    assert (full_cycles > 0) else report_error("instruction queue never held four instructions");

    $display("Writes checked: %0d, errors: %0d, timeouts: %0d", writes, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/result_queue.sv
/* Result queue to the register file */

`timescale 1ns/1ps
`default_nettype none

`include "vmul_consts.svh"

module result_queue (
  input  logic             clk_i,
  input  logic             rst_ni,
  vmul_result_if.consumer  res,
  input  vmul_pkg::vid_t   wr_id_i,
  input  vmul_pkg::vaddr_t wr_addr_i,
  input  vmul_pkg::strb_t  wr_be_i,
  output logic             result_req_o,
  output vmul_pkg::vid_t   result_id_o,
  output vmul_pkg::vaddr_t result_addr_o,
  output vmul_pkg::elen_t  result_wdata_o,
  output vmul_pkg::strb_t  result_be_o,
  input  logic             result_gnt_i,
  output logic             commit_o
);

  localparam int unsigned Depth = `VMUL_RESQ_DEPTH;

  typedef logic [$clog2(Depth)-1:0] pnt_t;
  typedef logic [$clog2(Depth):0]   cnt_t;

  typedef struct packed {
    vmul_pkg::vid_t   id;
    vmul_pkg::vaddr_t addr;
    vmul_pkg::elen_t  wdata;
    vmul_pkg::strb_t  be;
  } payload_t;

  payload_t queue_q [Depth];
  pnt_t     wr_pnt_q;
  pnt_t     rd_pnt_q;
  cnt_t     cnt_q;
  logic     push;
  logic     pop;

  assign res.ready = (cnt_q != cnt_t'(Depth));
  assign push      = res.valid && res.ready;
  assign pop       = result_req_o && result_gnt_i;
  assign commit_o  = pop;

  // Head entry drives the write port
  assign result_req_o   = (cnt_q != '0);
  assign result_id_o    = queue_q[rd_pnt_q].id;
  assign result_addr_o  = queue_q[rd_pnt_q].addr;
  assign result_wdata_o = queue_q[rd_pnt_q].wdata;
  assign result_be_o    = queue_q[rd_pnt_q].be;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_pnt_q <= (wr_pnt_q == pnt_t'(Depth-1)) ? '0 : wr_pnt_q + 1'b1;
      if (pop) rd_pnt_q <= (rd_pnt_q == pnt_t'(Depth-1)) ? '0 : rd_pnt_q + 1'b1;
      cnt_q <= cnt_q + cnt_t'(push) - cnt_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_pnt_q] <= '{
        id:    wr_id_i,
        addr:  wr_addr_i,
        wdata: res.wdata,
        be:    wr_be_i
      };
    end
  end

endmodule

`default_nettype wire

//--- hw/vinsn_queue.sv
/* Vector instruction queue */

`timescale 1ns/1ps
`default_nettype none

`include "vmul_consts.svh"

module vinsn_queue (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vmul_pkg::vmul_operation_t op_i,
  input  logic                      op_valid_i,
  output logic                      op_ready_o,
  input  logic [2:0]                operand_valid_i,
  output logic [2:0]                operand_ready_o,
  output vmul_pkg::vmul_operation_t issue_op_o,
  output logic                      issue_valid_o,
  input  logic                      issue_ready_i,
  output vmul_pkg::vew_e            processing_vsew_o,
  vmul_result_if.monitor            res,
  output vmul_pkg::vid_t            wr_id_o,
  output vmul_pkg::vaddr_t          wr_addr_o,
  output vmul_pkg::strb_t           wr_be_o,
  input  logic                      commit_i,
  output logic [`VMUL_NR_VINSN-1:0] vinsn_done_o
);

  localparam int unsigned Depth = `VMUL_VINSN_DEPTH;

  typedef logic [$clog2(Depth)-1:0] pnt_t;
  typedef logic [$clog2(Depth):0]   cnt_t;

  // Phase pointers, instructions per phase and elements left in the head one
  typedef struct packed {
    pnt_t            accept_pnt;
    pnt_t            issue_pnt;
    pnt_t            proc_pnt;
    pnt_t            commit_pnt;
    cnt_t            issue_cnt;
    cnt_t            proc_cnt;
    cnt_t            commit_cnt;
    vmul_pkg::vlen_t issue_el;
    vmul_pkg::vlen_t proc_el;
    vmul_pkg::vlen_t commit_el;
  } ctrl_t;

  ctrl_t                                 ctrl_d, ctrl_q;
  vmul_pkg::vmul_operation_t [Depth-1:0] vinsn_d, vinsn_q;

  vmul_pkg::vmul_operation_t issue_insn;
  vmul_pkg::vmul_operation_t proc_insn;
  vmul_pkg::vmul_operation_t commit_insn;
  logic                      use_vs1;
  logic                      use_vd;
  logic                      issue_fire;
  logic                      proc_fire;
  vmul_pkg::vlen_t           proc_step;
  vmul_pkg::vlen_t           proc_done_el;
  vmul_pkg::vlen_t           proc_bytes;

  // Elements covered by the next word, at most the remaining ones
  function automatic vmul_pkg::vlen_t elem_step(vmul_pkg::vew_e ew, vmul_pkg::vlen_t rem);
    vmul_pkg::vlen_t per_word;
    per_word = vmul_pkg::vlen_t'(1) << (2'd3 - ew);
    return (rem < per_word) ? rem : per_word;
  endfunction

  assign issue_insn  = vinsn_q[ctrl_q.issue_pnt];
  assign proc_insn   = vinsn_q[ctrl_q.proc_pnt];
  assign commit_insn = vinsn_q[ctrl_q.commit_pnt];

  //////////////////////////////////////////////////
  // Issue handshake
  //////////////////////////////////////////////////

  assign use_vs1 = !issue_insn.use_scalar_op;
  assign use_vd  = (issue_insn.op == vmul_pkg::VMACC);

  assign issue_op_o    = issue_insn;
  assign issue_valid_o = (ctrl_q.issue_cnt != '0) && operand_valid_i[1] &&
                         (operand_valid_i[0] || !use_vs1) &&
                         (operand_valid_i[2] || !use_vd);
  assign issue_fire      = issue_valid_o && issue_ready_i;
  assign operand_ready_o = issue_fire ? {use_vd, 1'b1, use_vs1} : 3'b000;

  //////////////////////////////////////////////////
  // Result word tagging
  //////////////////////////////////////////////////

  assign processing_vsew_o = proc_insn.vsew;
  assign proc_fire         = res.valid && res.ready;
  assign proc_step         = elem_step(proc_insn.vsew, ctrl_q.proc_el);
  assign proc_done_el      = proc_insn.vl - ctrl_q.proc_el;
  assign proc_bytes        = proc_step << proc_insn.vsew;

  assign wr_id_o   = proc_insn.id;
  assign wr_addr_o = proc_insn.vd_addr +
                     vmul_pkg::vaddr_t'(proc_done_el >> (2'd3 - proc_insn.vsew));

  // Tail word enables only the bytes of the remaining elements
  always_comb begin
    for (int b = 0; b < $bits(vmul_pkg::strb_t); b++) begin
      wr_be_o[b] = vmul_pkg::vlen_t'(b) < proc_bytes;
    end
  end

  //////////////////////////////////////////////////
  // Queue control
  //////////////////////////////////////////////////

  assign op_ready_o = (ctrl_q.commit_cnt != cnt_t'(Depth));

  always_comb begin
    ctrl_d       = ctrl_q;
    vinsn_d      = vinsn_q;
    vinsn_done_o = '0;

    if (issue_fire) begin
      ctrl_d.issue_el = ctrl_q.issue_el - elem_step(issue_insn.vsew, ctrl_q.issue_el);
      if (ctrl_d.issue_el == '0) begin
        ctrl_d.issue_cnt = ctrl_q.issue_cnt - 1'b1;
        ctrl_d.issue_pnt = ctrl_q.issue_pnt + 1'b1;
        ctrl_d.issue_el  = vinsn_q[ctrl_d.issue_pnt].vl;
      end
    end

    if (proc_fire) begin
      ctrl_d.proc_el = ctrl_q.proc_el - proc_step;
      if (ctrl_d.proc_el == '0) begin
        ctrl_d.proc_cnt = ctrl_q.proc_cnt - 1'b1;
        ctrl_d.proc_pnt = ctrl_q.proc_pnt + 1'b1;
        ctrl_d.proc_el  = vinsn_q[ctrl_d.proc_pnt].vl;
      end
    end

    // Done pulses with the grant of the last word
    if (commit_i) begin
      ctrl_d.commit_el = ctrl_q.commit_el - elem_step(commit_insn.vsew, ctrl_q.commit_el);
      if (ctrl_d.commit_el == '0) begin
        vinsn_done_o[commit_insn.id] = 1'b1;
        ctrl_d.commit_cnt = ctrl_q.commit_cnt - 1'b1;
        ctrl_d.commit_pnt = ctrl_q.commit_pnt + 1'b1;
        ctrl_d.commit_el  = vinsn_q[ctrl_d.commit_pnt].vl;
      end
    end

    // Zero-length instructions are acknowledged and dropped
    if (op_valid_i && op_ready_o && (op_i.vl != '0)) begin
      vinsn_d[ctrl_q.accept_pnt] = op_i;
      if (ctrl_d.issue_cnt == '0) ctrl_d.issue_el = op_i.vl;
      if (ctrl_d.proc_cnt == '0) ctrl_d.proc_el = op_i.vl;
      if (ctrl_d.commit_cnt == '0) ctrl_d.commit_el = op_i.vl;
      ctrl_d.accept_pnt = ctrl_q.accept_pnt + 1'b1;
      ctrl_d.issue_cnt  = ctrl_d.issue_cnt + 1'b1;
      ctrl_d.proc_cnt   = ctrl_d.proc_cnt + 1'b1;
      ctrl_d.commit_cnt = ctrl_d.commit_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q  <= '0;
      vinsn_q <= '0;
    end else begin
      ctrl_q  <= ctrl_d;
      vinsn_q <= vinsn_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/vmul/simd_mul.sv
/* Pipelined SIMD integer multiplier */

`timescale 1ns/1ps
`default_nettype none

module simd_mul #(
  parameter vmul_pkg::vew_e ElementWidth = vmul_pkg::EW64,
  parameter int unsigned    NumPipeRegs  = 1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  vmul_pkg::elen_t   operand_a_i,
  input  vmul_pkg::elen_t   operand_b_i,
  input  vmul_pkg::elen_t   operand_c_i,
  input  vmul_pkg::mul_op_e op_i,
  output vmul_pkg::elen_t   result_o,
  input  logic              valid_i,
  output logic              ready_o,
  input  logic              ready_i,
  output logic              valid_o
);

  localparam int unsigned DataWidth = $bits(vmul_pkg::elen_t);
  localparam int unsigned Ew        = 8 << int'(ElementWidth);
  localparam int unsigned NumElem   = DataWidth / Ew;

  vmul_pkg::elen_t result_d;

  //////////////////////////////////////////////////
  // Element arithmetic
  //////////////////////////////////////////////////

  for (genvar e = 0; e < NumElem; e++) begin : gen_elem
    logic [Ew-1:0]   a;
    logic [Ew-1:0]   b;
    logic [Ew-1:0]   c;
    logic [2*Ew-1:0] prod;

    assign a    = operand_a_i[e*Ew +: Ew];
    assign b    = operand_b_i[e*Ew +: Ew];
    assign c    = operand_c_i[e*Ew +: Ew];
    assign prod = a * b;

    // Low half for VMUL, high half for VMULHU, accumulate for VMACC
    assign result_d[e*Ew +: Ew] = (op_i == vmul_pkg::VMULHU) ? prod[2*Ew-1:Ew] :
                                  (op_i == vmul_pkg::VMACC)  ? c + prod[Ew-1:0] :
                                                               prod[Ew-1:0];
  end

  //////////////////////////////////////////////////
  // Pipeline
  //////////////////////////////////////////////////

  logic [NumPipeRegs-1:0] valid_q;
  vmul_pkg::elen_t        data_q [NumPipeRegs];
  logic                   stall;

  // All stages hold while the last one waits on the consumer
  assign stall   = valid_q[NumPipeRegs-1] && !ready_i;
  assign ready_o = !stall;
  assign valid_o = valid_q[NumPipeRegs-1];
  assign result_o = data_q[NumPipeRegs-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (!stall) begin
      valid_q[0] <= valid_i;
      for (int i = 1; i < NumPipeRegs; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      data_q[0] <= result_d;
      for (int i = 1; i < NumPipeRegs; i++) begin
        data_q[i] <= data_q[i-1];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/vmul/vmul_cluster.sv
/* Multiplier cluster */

`timescale 1ns/1ps
`default_nettype none

`include "vmul_consts.svh"

module vmul_cluster (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vmul_pkg::vmul_operation_t issue_op_i,
  input  logic                      issue_valid_i,
  output logic                      issue_ready_o,
  input  vmul_pkg::vew_e            processing_vsew_i,
  input  vmul_pkg::elen_t [2:0]     operand_i,
  vmul_result_if.producer           res
);

  localparam int unsigned Lat [4] = '{
    `VMUL_LAT_EW8, `VMUL_LAT_EW16, `VMUL_LAT_EW32, `VMUL_LAT_EW64
  };

  vmul_pkg::elen_t       scalar_op;
  vmul_pkg::elen_t       operand_a;
  vmul_pkg::elen_t [3:0] mul_result;
  logic            [3:0] mul_in_valid;
  logic            [3:0] mul_in_ready;
  logic            [3:0] mul_out_valid;
  logic            [3:0] mul_out_ready;

  // Scalar replicated once per element
  always_comb begin
    unique case (issue_op_i.vsew)
      vmul_pkg::EW64: scalar_op = issue_op_i.scalar_op;
      vmul_pkg::EW32: scalar_op = {2{issue_op_i.scalar_op[31:0]}};
      vmul_pkg::EW16: scalar_op = {4{issue_op_i.scalar_op[15:0]}};
      default:        scalar_op = {8{issue_op_i.scalar_op[7:0]}};
    endcase
  end

  assign operand_a = issue_op_i.use_scalar_op ? scalar_op : operand_i[0];

  //////////////////////////////////////////////////
  // One multiplier per element width
  //////////////////////////////////////////////////

  for (genvar w = 0; w < 4; w++) begin : gen_mul
    simd_mul #(
      .ElementWidth (vmul_pkg::vew_e'(w)),
      .NumPipeRegs  (Lat[w])
    ) simd_mul_inst (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .operand_a_i (operand_a),
      .operand_b_i (operand_i[1]),
      .operand_c_i (operand_i[2]),
      .op_i        (issue_op_i.op),
      .result_o    (mul_result[w]),
      .valid_i     (mul_in_valid[w]),
      .ready_o     (mul_in_ready[w]),
      .ready_i     (mul_out_ready[w]),
      .valid_o     (mul_out_valid[w])
    );
  end

  // Issue side follows the issue width, result side the processing width
  always_comb begin
    mul_in_valid                   = '0;
    mul_in_valid[issue_op_i.vsew]  = issue_valid_i;
    issue_ready_o                  = mul_in_ready[issue_op_i.vsew];

    mul_out_ready                    = '0;
    mul_out_ready[processing_vsew_i] = res.ready;
    res.valid                        = mul_out_valid[processing_vsew_i];
    res.wdata                        = mul_result[processing_vsew_i];
  end

endmodule

`default_nettype wire

//--- hw/vmul_unit.sv
/* Vector integer multiply unit */

`timescale 1ns/1ps
`default_nettype none

`include "vmul_consts.svh"

module vmul_unit (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Instruction
  input  vmul_pkg::vmul_operation_t op_i,
  input  logic                      op_valid_i,
  output logic                      op_ready_o,
  // Operand queues: vs1, vs2, vd
  input  vmul_pkg::elen_t [2:0]     operand_i,
  input  logic [2:0]                operand_valid_i,
  output logic [2:0]                operand_ready_o,
  // Register file write port
  output logic                      result_req_o,
  output vmul_pkg::vid_t            result_id_o,
  output vmul_pkg::vaddr_t          result_addr_o,
  output vmul_pkg::elen_t           result_wdata_o,
  output vmul_pkg::strb_t           result_be_o,
  input  logic                      result_gnt_i,
  output logic [`VMUL_NR_VINSN-1:0] vinsn_done_o
);

  vmul_pkg::vmul_operation_t issue_op;
  logic                      issue_valid;
  logic                      issue_ready;
  vmul_pkg::vew_e            processing_vsew;
  vmul_pkg::vid_t            wr_id;
  vmul_pkg::vaddr_t          wr_addr;
  vmul_pkg::strb_t           wr_be;
  logic                      commit;

  vmul_result_if res_if ();

  vinsn_queue vinsn_queue_inst (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .op_i              (op_i),
    .op_valid_i        (op_valid_i),
    .op_ready_o        (op_ready_o),
    .operand_valid_i   (operand_valid_i),
    .operand_ready_o   (operand_ready_o),
    .issue_op_o        (issue_op),
    .issue_valid_o     (issue_valid),
    .issue_ready_i     (issue_ready),
    .processing_vsew_o (processing_vsew),
    .res               (res_if.monitor),
    .wr_id_o           (wr_id),
    .wr_addr_o         (wr_addr),
    .wr_be_o           (wr_be),
    .commit_i          (commit),
    .vinsn_done_o      (vinsn_done_o)
  );

  vmul_cluster vmul_cluster_inst (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .issue_op_i        (issue_op),
    .issue_valid_i     (issue_valid),
    .issue_ready_o     (issue_ready),
    .processing_vsew_i (processing_vsew),
    .operand_i         (operand_i),
    .res               (res_if.producer)
  );

  result_queue result_queue_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .res            (res_if.consumer),
    .wr_id_i        (wr_id),
    .wr_addr_i      (wr_addr),
    .wr_be_i        (wr_be),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i),
    .commit_o       (commit)
  );

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/vmul_pkg.sv
common/vmul_result_if.sv
hw/vmul/simd_mul.sv
hw/vmul/vmul_cluster.sv
hw/vinsn_queue.sv
hw/result_queue.sv
hw/vmul_unit.sv
dv/tb_vmul_unit.sv
